// ==== hdl/cpu_isa_pkg.sv ====
package cpu_isa_pkg;

	typedef logic [15:0] word_t;
	typedef logic [31:0] instr_t;
	typedef logic [3:0]  reg_addr_t;
	typedef logic [7:0]  imem_addr_t;
	typedef logic [7:0]  dmem_addr_t;
	typedef logic [11:0] imm_t;
	typedef logic [4:0]  alu_op_t;
	typedef logic [2:0]  tf_code_t;

	typedef enum logic [2:0] {
		CLS_BRANCH = 3'b000,
		CLS_ALU    = 3'b001,
		CLS_CONST  = 3'b010,
		CLS_MEM    = 3'b100,
		CLS_JUMP   = 3'b110,
		CLS_HALT   = 3'b111
	} instr_class_e;

	localparam alu_op_t ALU_ADD   = 5'b00000;	// arithmetic, O S C Z
	localparam alu_op_t ALU_SUB   = 5'b00001;
	localparam alu_op_t ALU_INC   = 5'b00010;
	localparam alu_op_t ALU_DEC   = 5'b00011;
	localparam alu_op_t ALU_SHL   = 5'b01000;	// shifts, S C Z
	localparam alu_op_t ALU_SHR   = 5'b01001;
	localparam alu_op_t ALU_ZEROS = 5'b10000;	// Z only
	localparam alu_op_t ALU_AND   = 5'b10001;	// logic, S Z
	localparam alu_op_t ALU_OR    = 5'b10010;
	localparam alu_op_t ALU_PASSB = 5'b10011;
	localparam alu_op_t ALU_XOR   = 5'b10100;
	localparam alu_op_t ALU_NOT   = 5'b10101;
	localparam alu_op_t ALU_ONES  = 5'b11111;	// no flags

	localparam tf_code_t TF_ZERO    = 3'b000;
	localparam tf_code_t TF_NONZERO = 3'b001;
	localparam tf_code_t TF_NEG     = 3'b010;
	localparam tf_code_t TF_LINK    = 3'b011;	// jal in the jump class
	localparam tf_code_t TF_CARRY   = 3'b100;
	localparam tf_code_t TF_OVF     = 3'b101;
	localparam tf_code_t TF_ALWAYS  = 3'b110;
	localparam tf_code_t TF_NONE    = 3'b111;

	localparam instr_t INSTR_HALT = {CLS_HALT, 29'd0};

	// layout: class[31:29] op[28:24] rd[23:20] ra[19:16] rb[15:12] imm[11:0]
	function automatic instr_class_e instr_class(instr_t i);
		return instr_class_e'(i[31:29]);
	endfunction

	function automatic alu_op_t instr_op(instr_t i);
		return i[28:24];
	endfunction

	function automatic reg_addr_t instr_rd(instr_t i);
		return i[23:20];
	endfunction

	function automatic reg_addr_t instr_ra(instr_t i);
		return i[19:16];
	endfunction

	function automatic reg_addr_t instr_rb(instr_t i);
		return i[15:12];
	endfunction

	function automatic imm_t instr_imm(instr_t i);
		return i[11:0];
	endfunction

endpackage

// ==== hdl/cpu_ctrl_pkg.sv ====
package cpu_ctrl_pkg;

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_IF,
		ST_ID,
		ST_EX,
		ST_WB
	} ctrl_state_e;

	typedef logic [3:0] flags_t;	// O S C Z
	localparam int FLG_O = 3;
	localparam int FLG_S = 2;
	localparam int FLG_C = 1;
	localparam int FLG_Z = 0;

	typedef logic [2:0] flag_wr_t;
	localparam flag_wr_t FW_NONE = 3'b000;
	localparam flag_wr_t FW_Z    = 3'b001;
	localparam flag_wr_t FW_SZ   = 3'b010;
	localparam flag_wr_t FW_SCZ  = 3'b011;
	localparam flag_wr_t FW_OSCZ = 3'b100;

	typedef enum logic [1:0] {
		WB_LINK = 2'b00,
		WB_MEM  = 2'b01,
		WB_ALU  = 2'b10
	} wb_src_e;

	typedef logic [11:0] apb_addr_t;
	localparam logic [3:0] APB_RGN_IMEM = 4'h0;	// 0x000-0x0ff, write only
	localparam logic [3:0] APB_RGN_DMEM = 4'h1;	// 0x100-0x1ff
	localparam logic [7:0] APB_REG_PAGE = 8'h20;	// 0x200-0x20f

endpackage

// ==== hdl/cpu_ifaces.sv ====
`timescale 1ns/1ps

interface ctrl_bus;
	import cpu_isa_pkg::*;
	import cpu_ctrl_pkg::*;

	alu_op_t  op_alu;
	tf_code_t op_tf;	// branch condition
	logic     op_se;	// sign-extend immediate
	logic     s_mxse;	// B operand from immediate
	logic     w_pc;
	logic     w_dm;
	logic     w_rb;
	flag_wr_t w_rf;
	wb_src_e  s_mxrb;

	modport ctrl (output op_alu, op_tf, op_se, s_mxse, w_pc, w_dm, w_rb, w_rf, s_mxrb);
	modport exe (input op_alu, op_tf, op_se, s_mxse, w_rf);
	modport fetch (input w_pc);
	modport wb (input w_dm, w_rb, s_mxrb);
endinterface

interface apb_bus;
	import cpu_isa_pkg::*;
	import cpu_ctrl_pkg::*;

	logic      psel;
	logic      penable;
	logic      pwrite;
	apb_addr_t paddr;
	word_t     pwdata;
	word_t     prdata;
	logic      pready;

	modport imem_slave (input psel, penable, pwrite, paddr, pwdata);
	modport main_slave (input psel, penable, pwrite, paddr, pwdata, output prdata, pready);
endinterface

// ==== hdl/fetch_stage.sv ====
`timescale 1ns/1ps

module fetch_stage #(
	parameter int IMEM_DEPTH = 256
) (
	input  logic                    CLK,
	input  logic                    rst_n,
	ctrl_bus.fetch                  ctrl,
	apb_bus.imem_slave              apb,
	input  logic                    pc_load,
	input  cpu_isa_pkg::imem_addr_t pc_target,
	output cpu_isa_pkg::instr_t     instr,
	output cpu_isa_pkg::imem_addr_t pc
);
	import cpu_isa_pkg::*;
	import cpu_ctrl_pkg::*;

	instr_t     imem [IMEM_DEPTH];
	imem_addr_t fetch_addr;
	imem_addr_t load_idx;
	logic       load_wr;

	// a halt still in the IR means this IF opens a new run
	assign fetch_addr = (instr_class(instr) == CLS_HALT) ? '0 : pc;

	// two APB words per instruction, low half at the even address
	assign load_idx = {1'b0, apb.paddr[7:1]};
	assign load_wr = apb.psel && apb.penable && apb.pwrite &&
	                 (apb.paddr[11:8] == APB_RGN_IMEM);

	always_ff @(posedge CLK) begin
		if (load_wr) begin
			if (apb.paddr[0])
				imem[load_idx][31:16] <= apb.pwdata;
			else
				imem[load_idx][15:0] <= apb.pwdata;
		end
	end

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			instr <= INSTR_HALT;	// idle IR looks like a halt
			pc    <= '0;
		end else if (ctrl.w_pc) begin
			instr <= imem[fetch_addr];
			pc    <= fetch_addr + 1'b1;	// PC+1 at end of IF
		end else if (pc_load) begin
			pc <= pc_target;	// taken branch or jump, end of EX
		end
	end

	a_pc_range: assert property (@(posedge CLK) disable iff (!rst_n)
		int'(pc) < IMEM_DEPTH);

endmodule

// ==== hdl/control_unit.sv ====
`timescale 1ns/1ps

module control_unit (
	input  logic                CLK,
	input  logic                rst_n,
	input  logic                start,
	input  cpu_isa_pkg::instr_t instr,
	ctrl_bus.ctrl               ctrl,
	output logic                busy
);
	import cpu_isa_pkg::*;
	import cpu_ctrl_pkg::*;

	ctrl_state_e  state;
	ctrl_state_e  next_state;
	instr_class_e cls;
	alu_op_t      op;

	// decoded in ID, shown in EX and WB
	alu_op_t  dec_alu;
	tf_code_t dec_tf;
	logic     dec_se;
	logic     dec_mxse;
	logic     dec_dm;
	logic     dec_rb;
	flag_wr_t dec_rf;
	wb_src_e  dec_mxrb;

	function automatic flag_wr_t flag_wr_for(alu_op_t code);
		if (code == ALU_ONES)
			return FW_NONE;
		if (code == ALU_ZEROS)
			return FW_Z;
		case (code[4:3])
			2'b00:   return FW_OSCZ;	// arithmetic
			2'b01:   return FW_SCZ;	// shifts
			default: return FW_SZ;	// logic
		endcase
	endfunction

	assign cls = instr_class(instr);
	assign op = instr_op(instr);
	assign busy = (state != ST_IDLE);

	always_comb begin
		next_state = state;
		case (state)
			ST_IDLE: begin
				if (start)
					next_state = ST_IF;
			end
			ST_IF:   next_state = ST_ID;
			ST_ID:   next_state = (cls == CLS_HALT) ? ST_IDLE : ST_EX;
			ST_EX:   next_state = ST_WB;
			ST_WB:   next_state = ST_IF;
			default: next_state = ST_IDLE;
		endcase
	end

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n)
			state <= ST_IDLE;
		else
			state <= next_state;
	end

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			dec_alu  <= ALU_PASSB;
			dec_tf   <= TF_NONE;
			dec_se   <= 1'b0;
			dec_mxse <= 1'b0;
			dec_dm   <= 1'b0;
			dec_rb   <= 1'b0;
			dec_rf   <= FW_NONE;
			dec_mxrb <= WB_ALU;
		end else if (state == ST_ID) begin
			dec_alu  <= ALU_PASSB;
			dec_tf   <= TF_NONE;
			dec_se   <= 1'b0;
			dec_mxse <= 1'b0;
			dec_dm   <= 1'b0;
			dec_rb   <= 1'b0;
			dec_rf   <= FW_NONE;
			dec_mxrb <= WB_ALU;
			case (cls)
				CLS_ALU: begin
					dec_alu <= op;
					dec_rb  <= 1'b1;
					dec_rf  <= flag_wr_for(op);
				end
				CLS_CONST: begin
					dec_alu  <= op;
					dec_se   <= 1'b1;
					dec_mxse <= 1'b1;
					dec_rb   <= 1'b1;
				end
				CLS_MEM: begin
					dec_dm   <= op[0];	// store
					dec_rb   <= ~op[0];	// load
					dec_mxrb <= WB_MEM;
				end
				CLS_BRANCH: begin
					dec_tf   <= op[2:0];
					dec_mxse <= 1'b1;	// target from immediate
				end
				CLS_JUMP: begin
					dec_tf   <= op[2:0];
					dec_rb   <= (op[2:0] == TF_LINK);	// jal only
					dec_mxrb <= WB_LINK;
				end
				default: ;	// halt
			endcase
		end
	end

	always_comb begin
		ctrl.op_alu = ALU_PASSB;
		ctrl.op_tf  = TF_NONE;
		ctrl.op_se  = 1'b0;
		ctrl.s_mxse = 1'b0;
		ctrl.w_pc   = 1'b0;
		ctrl.w_dm   = 1'b0;
		ctrl.w_rb   = 1'b0;
		ctrl.w_rf   = FW_NONE;
		ctrl.s_mxrb = WB_LINK;
		case (state)
			ST_IF: ctrl.w_pc = 1'b1;
			ST_EX: begin
				ctrl.op_alu = dec_alu;
				ctrl.op_tf  = dec_tf;
				ctrl.op_se  = dec_se;
				ctrl.s_mxse = dec_mxse;
				ctrl.w_dm   = dec_dm;
			end
			ST_WB: begin
				ctrl.w_rb   = dec_rb;
				ctrl.w_rf   = dec_rf;
				ctrl.s_mxrb = dec_mxrb;
			end
			default: ;
		endcase
	end

	a_state_legal: assert property (@(posedge CLK) disable iff (!rst_n)
		state inside {ST_IDLE, ST_IF, ST_ID, ST_EX, ST_WB});

	// a store never also writes a register in its WB
	a_dm_rb_excl: assert property (@(posedge CLK) disable iff (!rst_n)
		ctrl.w_dm |=> !ctrl.w_rb);

endmodule

// ==== hdl/execute_stage.sv ====
`timescale 1ns/1ps

module execute_stage (
	input  logic                    CLK,
	input  logic                    rst_n,
	ctrl_bus.exe                    ctrl,
	input  cpu_isa_pkg::imm_t       imm,
	input  cpu_isa_pkg::imem_addr_t pc,
	input  cpu_isa_pkg::word_t      ra_data,
	input  cpu_isa_pkg::word_t      rb_data,
	output cpu_isa_pkg::word_t      alu_result,
	output logic                    pc_load,
	output cpu_isa_pkg::imem_addr_t pc_target,
	output cpu_ctrl_pkg::flags_t    flags
);
	import cpu_isa_pkg::*;
	import cpu_ctrl_pkg::*;

	word_t       imm_ext;
	word_t       opnd_b;
	word_t       arith_b;
	logic [16:0] arith;
	logic        b_eff_msb;
	logic        overflow;
	word_t       result;
	flags_t      flags_calc;
	flags_t      flags_new;
	flags_t      flag_mask;
	logic        taken;
	imem_addr_t  jump_target;

	assign imm_ext = ctrl.op_se ? {{4{imm[11]}}, imm} : {4'd0, imm};
	assign opnd_b = ctrl.s_mxse ? imm_ext : rb_data;
	assign arith_b = ctrl.op_alu[1] ? 16'd1 : opnd_b;	// inc and dec
	assign arith = ctrl.op_alu[0] ? ({1'b0, ra_data} - {1'b0, arith_b})
	                              : ({1'b0, ra_data} + {1'b0, arith_b});
	assign b_eff_msb = arith_b[15] ^ ctrl.op_alu[0];	// subtract flips B sign
	assign overflow = (ra_data[15] == b_eff_msb) && (arith[15] != ra_data[15]);

	always_comb begin
		result = arith[15:0];
		flags_calc = '0;
		flags_calc[FLG_C] = arith[16];	// carry or borrow
		case (ctrl.op_alu)
			ALU_SHL: begin
				result = ra_data << 1;
				flags_calc[FLG_C] = ra_data[15];
			end
			ALU_SHR: begin
				result = ra_data >> 1;
				flags_calc[FLG_C] = ra_data[0];
			end
			ALU_ZEROS: result = '0;
			ALU_AND:   result = ra_data & opnd_b;
			ALU_OR:    result = ra_data | opnd_b;
			ALU_XOR:   result = ra_data ^ opnd_b;
			ALU_NOT:   result = ~ra_data;
			ALU_PASSB: result = opnd_b;
			ALU_ONES:  result = '1;
			default: ;
		endcase
		flags_calc[FLG_O] = overflow;
		flags_calc[FLG_S] = result[15];
		flags_calc[FLG_Z] = (result == '0);
	end

	// captured each cycle, the EX value holds through WB
	always_ff @(posedge CLK) begin
		alu_result <= result;
		flags_new  <= flags_calc;
	end

	always_comb begin
		case (ctrl.w_rf)
			FW_Z:    flag_mask = 4'b0001;
			FW_SZ:   flag_mask = 4'b0101;
			FW_SCZ:  flag_mask = 4'b0111;
			FW_OSCZ: flag_mask = 4'b1111;
			default: flag_mask = 4'b0000;
		endcase
	end

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n)
			flags <= '0;
		else
			flags <= (flags & ~flag_mask) | (flags_new & flag_mask);
	end

	always_comb begin
		case (ctrl.op_tf)
			TF_ZERO:    taken = flags[FLG_Z];
			TF_NONZERO: taken = !flags[FLG_Z];
			TF_NEG:     taken = flags[FLG_S];
			TF_CARRY:   taken = flags[FLG_C];
			TF_OVF:     taken = flags[FLG_O];
			TF_ALWAYS:  taken = 1'b1;
			TF_LINK:    taken = 1'b1;
			default:    taken = 1'b0;
		endcase
	end

	// branches and jal go to the immediate, jr to ra
	assign jump_target = (ctrl.s_mxse || ctrl.op_tf == TF_LINK) ? imm[7:0] : ra_data[7:0];
	assign pc_target = taken ? jump_target : pc;
	assign pc_load = taken;

endmodule

// ==== hdl/writeback_stage.sv ====
`timescale 1ns/1ps

module writeback_stage #(
	parameter int DMEM_DEPTH = 256
) (
	input  logic                    CLK,
	input  logic                    rst_n,
	ctrl_bus.wb                     ctrl,
	apb_bus.main_slave              apb,
	input  cpu_isa_pkg::reg_addr_t  rd,
	input  cpu_isa_pkg::reg_addr_t  ra,
	input  cpu_isa_pkg::reg_addr_t  rb,
	input  cpu_isa_pkg::imem_addr_t pc,
	input  cpu_isa_pkg::word_t      alu_result,
	output cpu_isa_pkg::word_t      ra_data,
	output cpu_isa_pkg::word_t      rb_data
);
	import cpu_isa_pkg::*;
	import cpu_ctrl_pkg::*;

	word_t      regs [16];
	word_t      dmem [DMEM_DEPTH];
	word_t      mem_q;	// core load data, valid in WB
	word_t      apb_q;
	imem_addr_t link_pc;	// PC seen in EX, return address in WB
	word_t      wb_data;
	dmem_addr_t core_addr;
	dmem_addr_t apb_addr;
	logic       apb_access;
	logic       apb_dmem;
	logic       apb_reg;
	logic       rd_wait;	// dmem read wait state

	assign ra_data = regs[ra];
	assign rb_data = regs[rb];
	assign core_addr = ra_data[7:0];
	assign apb_addr = apb.paddr[7:0];

	assign apb_access = apb.psel && apb.penable;
	assign apb_dmem = (apb.paddr[11:8] == APB_RGN_DMEM);
	assign apb_reg = (apb.paddr[11:4] == APB_REG_PAGE);

	always_ff @(posedge CLK) begin
		mem_q <= dmem[core_addr];
		apb_q <= dmem[apb_addr];
		link_pc <= pc;
		if (ctrl.w_dm)
			dmem[core_addr] <= rb_data;	// store at end of EX
		else if (apb_access && apb.pwrite && apb_dmem)
			dmem[apb_addr] <= apb.pwdata;
	end

	always_comb begin
		case (ctrl.s_mxrb)
			WB_LINK: wb_data = {8'd0, link_pc};	// return address
			WB_MEM:  wb_data = mem_q;
			default: wb_data = alu_result;
		endcase
	end

	always_ff @(posedge CLK) begin
		if (ctrl.w_rb)
			regs[rd] <= wb_data;
	end

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n)
			rd_wait <= 1'b0;
		else
			rd_wait <= apb_access && !apb.pwrite && apb_dmem && !rd_wait;
	end

	assign apb.pready = apb_access && (apb.pwrite || !apb_dmem || rd_wait);
	assign apb.prdata = apb_reg ? regs[apb.paddr[3:0]] : apb_q;

	a_dmem_rd_wait: assert property (@(posedge CLK) disable iff (!rst_n)
		$rose(apb_access) && !apb.pwrite && apb_dmem |-> !apb.pready);

endmodule

// ==== hdl/cpu_top.sv ====
`timescale 1ns/1ps

module cpu_top #(
	parameter int IMEM_DEPTH = 256,
	parameter int DMEM_DEPTH = 256
) (
	input  logic               CLK,
	input  logic               rst_n,
	input  logic               start,
	output logic               busy,
	input  logic               psel,
	input  logic               penable,
	input  logic               pwrite,
	input  logic [11:0]        paddr,
	input  cpu_isa_pkg::word_t pwdata,
	output cpu_isa_pkg::word_t prdata,
	output logic               pready
);
	import cpu_isa_pkg::*;
	import cpu_ctrl_pkg::*;

	instr_t     instr;
	imem_addr_t pc;
	imem_addr_t pc_target;
	logic       pc_load;
	word_t      ra_data;
	word_t      rb_data;
	word_t      alu_result;
	flags_t     flags;

	ctrl_bus u_ctrl_bus ();
	apb_bus  u_apb_bus ();

	assign u_apb_bus.psel    = psel;
	assign u_apb_bus.penable = penable;
	assign u_apb_bus.pwrite  = pwrite;
	assign u_apb_bus.paddr   = paddr;
	assign u_apb_bus.pwdata  = pwdata;
	assign prdata = u_apb_bus.prdata;
	assign pready = u_apb_bus.pready;

	fetch_stage #(.IMEM_DEPTH(IMEM_DEPTH)) u_fetch (
		.CLK       (CLK),
		.rst_n     (rst_n),
		.ctrl      (u_ctrl_bus),
		.apb       (u_apb_bus),
		.pc_load   (pc_load),
		.pc_target (pc_target),
		.instr     (instr),
		.pc        (pc)
	);

	control_unit u_control (
		.CLK   (CLK),
		.rst_n (rst_n),
		.start (start),
		.instr (instr),
		.ctrl  (u_ctrl_bus),
		.busy  (busy)
	);

	execute_stage u_execute (
		.CLK        (CLK),
		.rst_n      (rst_n),
		.ctrl       (u_ctrl_bus),
		.imm        (instr_imm(instr)),
		.pc         (pc),
		.ra_data    (ra_data),
		.rb_data    (rb_data),
		.alu_result (alu_result),
		.pc_load    (pc_load),
		.pc_target  (pc_target),
		.flags      (flags)
	);

	writeback_stage #(.DMEM_DEPTH(DMEM_DEPTH)) u_writeback (
		.CLK        (CLK),
		.rst_n      (rst_n),
		.ctrl       (u_ctrl_bus),
		.apb        (u_apb_bus),
		.rd         (instr_rd(instr)),
		.ra         (instr_ra(instr)),
		.rb         (instr_rb(instr)),
		.pc         (pc),
		.alu_result (alu_result),
		.ra_data    (ra_data),
		.rb_data    (rb_data)
	);

	// flags only move inside a run
	a_flags_idle: assert property (@(posedge CLK) disable iff (!rst_n)
		!busy |=> $stable(flags));

endmodule

// ==== test/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock #(
	parameter int PERIOD_NS = 100
) (
	output logic CLK
);
	initial CLK = 1'b0;

	always #(PERIOD_NS / 2) CLK = ~CLK;	// 50/50 duty

endmodule

// ==== test/tb_cpu.sv ====
`timescale 1ns/1ps

module tb_cpu;
	import cpu_isa_pkg::*;

	localparam logic [11:0] DMEM_BASE = 12'h100;
	localparam logic [11:0] REG_BASE  = 12'h200;
	// about 130 instructions executed, about 900 cycles of APB traffic
	localparam int TIMEOUT_CYCLES = 2 * (4 * 130 + 900) + 10;

	logic        CLK;
	logic        rst_n;
	logic        start;
	logic        busy;
	logic        psel;
	logic        penable;
	logic        pwrite;
	logic [11:0] paddr;
	word_t       pwdata;
	word_t       prdata;
	logic        pready;

	int     errors = 0;
	int     checks = 0;
	int     tests = 0;
	int     cycle_count = 0;
	instr_t prog[$];

	tb_clock #(.PERIOD_NS(100)) u_clock (.CLK(CLK));

	cpu_top u_cpu_top (
		.CLK     (CLK),
		.rst_n   (rst_n),
		.start   (start),
		.busy    (busy),
		.psel    (psel),
		.penable (penable),
		.pwrite  (pwrite),
		.paddr   (paddr),
		.pwdata  (pwdata),
		.prdata  (prdata),
		.pready  (pready)
	);

	always @(posedge CLK) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	// layout class op rd ra rb imm
	function automatic instr_t encode(instr_class_e cls, alu_op_t op, reg_addr_t rd,
	                                  reg_addr_t ra, reg_addr_t rb, imm_t imm);
		return {cls, op, rd, ra, rb, imm};
	endfunction

	function automatic instr_t load_imm(reg_addr_t rd, imm_t imm);
		return encode(CLS_CONST, ALU_PASSB, rd, 4'd0, 4'd0, imm);
	endfunction

	function automatic instr_t add_imm(reg_addr_t rd, reg_addr_t ra, imm_t imm);
		return encode(CLS_CONST, ALU_ADD, rd, ra, 4'd0, imm);
	endfunction

	function automatic instr_t alu_rr(alu_op_t op, reg_addr_t rd, reg_addr_t ra, reg_addr_t rb);
		return encode(CLS_ALU, op, rd, ra, rb, 12'd0);
	endfunction

	function automatic instr_t mem_load(reg_addr_t rd, reg_addr_t ra);
		return encode(CLS_MEM, 5'd0, rd, ra, 4'd0, 12'd0);
	endfunction

	function automatic instr_t mem_store(reg_addr_t ra, reg_addr_t rb);
		return encode(CLS_MEM, 5'd1, 4'd0, ra, rb, 12'd0);
	endfunction

	function automatic instr_t branch_to(tf_code_t tf, int target);
		return encode(CLS_BRANCH, {2'b00, tf}, 4'd0, 4'd0, 4'd0, imm_t'(target));
	endfunction

	task automatic apb_access(input logic wr, input logic [11:0] addr, input word_t data,
	                          output word_t rdata, output int waits);
		@(posedge CLK);
		psel    <= 1'b1;
		penable <= 1'b0;
		pwrite  <= wr;
		paddr   <= addr;
		pwdata  <= data;
		@(posedge CLK);
		penable <= 1'b1;
		waits = 0;
		@(negedge CLK);
		while (!pready) begin
			waits++;
			@(negedge CLK);
		end
		rdata = prdata;
		@(posedge CLK);
		psel    <= 1'b0;
		penable <= 1'b0;
		pwrite  <= 1'b0;
	endtask

	task automatic apb_write(input logic [11:0] addr, input word_t data);
		word_t unused;
		int    waits;
		apb_access(1'b1, addr, data, unused, waits);
	endtask

	task automatic apb_read(input logic [11:0] addr, output word_t data, output int waits);
		apb_access(1'b0, addr, 16'd0, data, waits);
	endtask

	// two APB words per instruction, low half first
	task automatic load_program();
		foreach (prog[i]) begin
			apb_write(12'(2 * i), prog[i][15:0]);
			apb_write(12'(2 * i + 1), prog[i][31:16]);
		end
	endtask

	// counts the cycles busy stays high
	task automatic run_program(output int cycles);
		@(posedge CLK);
		start <= 1'b1;
		@(posedge CLK);
		start <= 1'b0;
		cycles = 0;
		@(negedge CLK);
		while (busy) begin
			cycles++;
			@(negedge CLK);
		end
	endtask

	task automatic check_word(input string what, input word_t got, input word_t exp);
		checks++;
		if (got !== exp) begin
			$display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic check_cycles(input string what, input int got, input int exp);
		checks++;
		if (got != exp) begin
			$display("[ERROR] %0t ns: %s took %0d cycles, expected %0d", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic check_reg(input reg_addr_t r, input word_t exp);
		word_t v;
		int    waits;
		apb_read(REG_BASE + 12'(r), v, waits);
		check_word($sformatf("r%0d", r), v, exp);
		check_cycles("register read wait", waits, 0);
	endtask

	task automatic check_dmem(input dmem_addr_t a, input word_t exp);
		word_t v;
		int    waits;
		apb_read(DMEM_BASE + 12'(a), v, waits);
		check_word($sformatf("dmem[%h]", a), v, exp);
		check_cycles("dmem read wait", waits, 1);
	endtask

	task automatic report_test(input string name, input int err_before);
		tests++;
		$display("%-12s %s", name, (errors == err_before) ? "ok" : "failed");
	endtask

	task automatic test_alu_ops();
		int    e0;
		int    cyc;
		word_t a;
		word_t b;
		e0 = errors;
		a = word_t'($urandom);
		b = word_t'($urandom);
		apb_write(DMEM_BASE + 12'h10, a);
		apb_write(DMEM_BASE + 12'h11, b);
		prog = {};
		prog.push_back(load_imm(1, 12'h10));
		prog.push_back(load_imm(2, 12'h11));
		prog.push_back(mem_load(3, 1));
		prog.push_back(mem_load(4, 2));
		prog.push_back(alu_rr(ALU_ADD, 5, 3, 4));
		prog.push_back(alu_rr(ALU_SUB, 6, 3, 4));
		prog.push_back(alu_rr(ALU_AND, 7, 3, 4));
		prog.push_back(alu_rr(ALU_OR, 8, 3, 4));
		prog.push_back(alu_rr(ALU_XOR, 9, 3, 4));
		prog.push_back(alu_rr(ALU_NOT, 10, 3, 0));
		prog.push_back(alu_rr(ALU_SHL, 11, 3, 0));
		prog.push_back(alu_rr(ALU_SHR, 12, 3, 0));
		prog.push_back(mem_store(1, 5));
		prog.push_back(load_imm(13, 12'h111));
		prog.push_back(load_imm(14, 12'h000));
		prog.push_back(alu_rr(ALU_DEC, 14, 14, 0));	// C=1 S=1
		prog.push_back(alu_rr(ALU_AND, 15, 14, 14));	// logic keeps C
		prog.push_back(branch_to(TF_CARRY, prog.size() + 2));
		prog.push_back(load_imm(13, 12'hbad));
		prog.push_back(alu_rr(ALU_ZEROS, 15, 0, 0));	// Z only
		prog.push_back(alu_rr(ALU_ONES, 15, 0, 0));	// no flags
		prog.push_back(branch_to(TF_ZERO, prog.size() + 2));
		prog.push_back(load_imm(13, 12'hbad));
		prog.push_back(branch_to(TF_NEG, prog.size() + 2));
		prog.push_back(load_imm(13, 12'hbad));
		prog.push_back(INSTR_HALT);
		load_program();
		run_program(cyc);
		check_dmem(8'h10, word_t'(a + b));
		check_reg(6, word_t'(a - b));
		check_reg(7, a & b);
		check_reg(8, a | b);
		check_reg(9, a ^ b);
		check_reg(10, ~a);
		check_reg(11, word_t'(a << 1));
		check_reg(12, a >> 1);
		check_reg(13, 16'h0111);
		check_reg(14, 16'hffff);
		check_reg(15, 16'hffff);
		report_test("alu_ops", e0);
	endtask

	task automatic test_const_ops();
		int e0;
		int cyc;
		e0 = errors;
		prog = {};
		prog.push_back(load_imm(1, 12'h123));
		prog.push_back(alu_rr(ALU_ZEROS, 3, 0, 0));	// Z=1
		prog.push_back(add_imm(4, 1, 12'hffb));
		prog.push_back(add_imm(5, 1, 12'h7ff));
		prog.push_back(load_imm(7, 12'h111));
		prog.push_back(branch_to(TF_ZERO, prog.size() + 2));
		prog.push_back(load_imm(7, 12'hbad));
		prog.push_back(alu_rr(ALU_AND, 9, 1, 1));	// Z=0
		prog.push_back(add_imm(6, 1, 12'hedd));	// zero result
		prog.push_back(branch_to(TF_NONZERO, prog.size() + 2));
		prog.push_back(load_imm(7, 12'hbad));
		prog.push_back(INSTR_HALT);
		load_program();
		run_program(cyc);
		check_reg(4, 16'h011e);	// 0x123 - 5
		check_reg(5, 16'h0922);	// 0x123 + 0x7ff
		check_reg(6, 16'h0000);	// 0x123 - 0x123
		check_reg(7, 16'h0111);
		report_test("const_ops", e0);
	endtask

	task automatic test_load_store();
		int         e0;
		int         cyc;
		word_t      w[3];
		dmem_addr_t d[3];
		e0 = errors;
		prog = {};
		for (int k = 0; k < 3; k++) begin
			w[k] = word_t'($urandom);
			d[k] = dmem_addr_t'(8'h40 * (k + 1) + $urandom_range(0, 63));
			apb_write(DMEM_BASE + 12'(k), w[k]);
			prog.push_back(load_imm(reg_addr_t'(1 + k), imm_t'(k)));
		end
		for (int k = 0; k < 3; k++)
			prog.push_back(mem_load(reg_addr_t'(4 + k), reg_addr_t'(1 + k)));
		for (int k = 0; k < 3; k++)
			prog.push_back(load_imm(reg_addr_t'(7 + k), imm_t'(d[k])));
		for (int k = 0; k < 3; k++)
			prog.push_back(mem_store(reg_addr_t'(7 + k), reg_addr_t'(4 + k)));
		for (int k = 0; k < 3; k++)
			prog.push_back(mem_load(reg_addr_t'(10 + k), reg_addr_t'(7 + k)));
		prog.push_back(INSTR_HALT);
		load_program();
		run_program(cyc);
		for (int k = 0; k < 3; k++) begin
			check_dmem(d[k], w[k]);
			check_reg(reg_addr_t'(10 + k), w[k]);
		end
		report_test("load_store", e0);
	endtask

	task automatic test_counted_loop();
		int e0;
		int cyc;
		int n;
		e0 = errors;
		n = $urandom_range(3, 9);
		prog = {};
		prog.push_back(load_imm(1, imm_t'(n)));
		prog.push_back(load_imm(2, 12'h000));
		prog.push_back(load_imm(3, 12'h030));
		prog.push_back(alu_rr(ALU_INC, 2, 2, 0));	// loop body at 3
		prog.push_back(alu_rr(ALU_DEC, 1, 1, 0));
		prog.push_back(branch_to(TF_NONZERO, 3));
		prog.push_back(mem_store(3, 2));
		prog.push_back(load_imm(4, 12'h222));	// fall-through marker
		prog.push_back(INSTR_HALT);
		load_program();
		run_program(cyc);
		check_dmem(8'h30, word_t'(n));
		check_reg(1, 16'h0000);
		check_reg(4, 16'h0222);
		report_test("loop", e0);
	endtask

	task automatic test_jal_jr();
		int e0;
		int cyc;
		e0 = errors;
		prog = {};
		prog.push_back(load_imm(1, 12'h050));
		prog.push_back(load_imm(2, 12'h001));
		prog.push_back(mem_store(1, 2));	// marker 1
		prog.push_back(alu_rr(ALU_INC, 1, 1, 0));
		prog.push_back(encode(CLS_JUMP, {2'b00, TF_LINK}, 14, 0, 0, 12'd9));	// jal at 4
		prog.push_back(load_imm(2, 12'h003));
		prog.push_back(mem_store(1, 2));	// marker 3
		prog.push_back(INSTR_HALT);
		prog.push_back(INSTR_HALT);
		prog.push_back(load_imm(2, 12'h002));	// subroutine at 9
		prog.push_back(mem_store(1, 2));	// marker 2
		prog.push_back(alu_rr(ALU_INC, 1, 1, 0));
		prog.push_back(encode(CLS_JUMP, {2'b00, TF_ALWAYS}, 0, 14, 0, 12'd0));	// jr r14
		load_program();
		run_program(cyc);
		check_dmem(8'h50, 16'h0001);
		check_dmem(8'h51, 16'h0002);
		check_dmem(8'h52, 16'h0003);
		check_reg(14, 16'd5);	// one past the jal
		report_test("jal_jr", e0);
	endtask

	task automatic test_timing();
		int    e0;
		int    cyc;
		int    n;
		int    waits;
		word_t v;
		word_t w;
		e0 = errors;
		n = $urandom_range(3, 10);
		prog = {};
		for (int k = 0; k < n; k++)
			prog.push_back(load_imm(reg_addr_t'(k), imm_t'(k)));
		prog.push_back(INSTR_HALT);
		load_program();
		run_program(cyc);
		check_cycles("straight program", cyc, 4 * n + 2);
		for (int k = 0; k < 3; k++) begin
			w = word_t'($urandom);
			apb_write(DMEM_BASE + 12'(8'h90 + k), w);
			apb_read(DMEM_BASE + 12'(8'h90 + k), v, waits);
			check_word("dmem read data", v, w);
			check_cycles("dmem read wait", waits, 1);
		end
		apb_read(REG_BASE + 12'd2, v, waits);
		check_word("r2", v, 16'd2);
		check_cycles("register read wait", waits, 0);
		report_test("timing", e0);
	endtask

	initial begin
		void'($urandom(59));
		rst_n   = 1'b0;
		start   = 1'b0;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
		paddr   = '0;
		pwdata  = '0;
		repeat (5) @(posedge CLK);
		rst_n <= 1'b1;
		@(posedge CLK);
		test_alu_ops();
		test_const_ops();
		test_load_store();
		test_counted_loop();
		test_jal_jr();
		test_timing();
		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

// ==== src.f ====
hdl/cpu_isa_pkg.sv
hdl/cpu_ctrl_pkg.sv
hdl/cpu_ifaces.sv
hdl/fetch_stage.sv
hdl/control_unit.sv
hdl/execute_stage.sv
hdl/writeback_stage.sv
hdl/cpu_top.sv
test/tb_clock.sv
test/tb_cpu.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_cpu
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, check $(LOG)"
	@echo "  clean  remove build output and log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@! grep -q "SIMULATION FAILED" $(LOG)
	@grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
